/* source/soc_pkg.sv */
// --------------------------------------------------
// soc package
// address map, bus request and response structs,
// the two-view bus address and the debug source
// --------------------------------------------------

`default_nettype none

package soc_pkg;

  // bus geometry
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  // region tags sit in address bits 31..24
  localparam logic [7:0] RomTag   = 8'h01;
  localparam logic [7:0] ClintTag = 8'h02;
  localparam logic [7:0] RamTag   = 8'h80;

  localparam int unsigned RomWords = 512;

  // timer register offsets within the clint region
  localparam logic [23:0] MsipOffset     = 24'h00_0000;
  localparam logic [23:0] MtimecmpOffset = 24'h00_4000;
  localparam logic [23:0] MtimeOffset    = 24'h00_BFF8;

  // base of the boot rom content rule
  localparam logic [31:0] RomHiBase = 32'hB007_0000;

  // --------------------------------------------------
  // bus types
  // --------------------------------------------------
  typedef struct packed {
    logic [7:0]  tag;
    logic [23:0] offset;
  } addr_region_t;

  // same word seen flat by the memories, tagged by the decoder
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    addr_region_t         region;
  } bus_addr_u;

  typedef struct packed {
    logic                 req;
    logic                 we;
    bus_addr_u            addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  // one debug source, reduced to a halt level and an exit code
  typedef struct packed {
    logic        halt_req;
    logic [31:0] exit_code;
  } dbg_src_t;

endpackage

`default_nettype wire

/* source/addr_decoder.sv */
// --------------------------------------------------
// address decoder
// routes each single-beat request to rom, ram or
// timer and returns a registered one-cycle response,
// with an error for anything outside the map
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module addr_decoder #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                             clk_i,
  input  logic                             ndmreset_n,
  input  soc_pkg::bus_req_t                bus_req_i,
  output soc_pkg::bus_rsp_t                bus_rsp_o,
  output soc_pkg::bus_req_t                rom_req_o,
  output soc_pkg::bus_req_t                ram_req_o,
  output soc_pkg::bus_req_t                clint_req_o,
  input  logic [soc_pkg::DataWidth-1:0]    rom_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0]    ram_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0]    clint_rdata_i,
  input  logic                             clint_hit_i
);
  import soc_pkg::*;

  localparam int unsigned RomBytes = RomWords * StrbWidth;
  localparam int unsigned RamBytes = RamWords * StrbWidth;

  typedef enum logic [1:0] {SelNone, SelRom, SelRam, SelClint} sel_e;

  bus_addr_u            req_addr;
  logic                 rom_sel, ram_sel, clint_sel;
  logic                 mapped;
  sel_e                 sel_d, sel_q;
  logic                 rvalid_q, err_q, rd_q;
  logic [DataWidth-1:0] clint_data_q;
  logic [DataWidth-1:0] rsp_data;

  // --------------------------------------------------
  // request cycle
  // --------------------------------------------------
  assign req_addr  = bus_req_i.addr;
  assign rom_sel   = (req_addr.region.tag == RomTag) &&
                     (32'(req_addr.region.offset) < RomBytes);
  assign ram_sel   = (req_addr.region.tag == RamTag) &&
                     (32'(req_addr.region.offset) < RamBytes);
  // the timer itself owns the offset check
  assign clint_sel = (req_addr.region.tag == ClintTag);
  assign mapped    = rom_sel | ram_sel | (clint_sel & clint_hit_i);

  always_comb begin
    rom_req_o       = bus_req_i;
    ram_req_o       = bus_req_i;
    clint_req_o     = bus_req_i;
    rom_req_o.req   = bus_req_i.req & rom_sel;
    ram_req_o.req   = bus_req_i.req & ram_sel;
    clint_req_o.req = bus_req_i.req & clint_sel;
  end

  always_comb begin
    sel_d = SelNone;
    if (rom_sel) sel_d = SelRom;
    else if (ram_sel) sel_d = SelRam;
    else if (clint_sel && clint_hit_i) sel_d = SelClint;
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rd_q     <= 1'b0;
      sel_q    <= SelNone;
    end else begin
      rvalid_q <= bus_req_i.req;
      err_q    <= bus_req_i.req & ~mapped;
      rd_q     <= bus_req_i.req & ~bus_req_i.we & mapped;
      sel_q    <= bus_req_i.req ? sel_d : SelNone;
    end
  end

  // timer data is combinational, so capture it here
  always_ff @(posedge clk_i) begin
    if (clint_req_o.req) clint_data_q <= clint_rdata_i;
  end

  // --------------------------------------------------
  // response cycle
  // --------------------------------------------------
  always_comb begin
    rsp_data = '0;
    if (rd_q) begin
      case (sel_q)
        SelRom:   rsp_data = rom_rdata_i;
        SelRam:   rsp_data = ram_rdata_i;
        SelClint: rsp_data = clint_data_q;
        default:  rsp_data = '0;
      endcase
    end
  end

  always_comb begin
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.err    = err_q;
    bus_rsp_o.rdata  = rsp_data;
  end

endmodule

`default_nettype wire

/* source/boot_rom.sv */
// --------------------------------------------------
// boot rom
// read-only table built from a fixed rule,
// read through one register
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                          clk_i,
  input  soc_pkg::bus_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IdxW     = $clog2(RomWords);
  localparam int unsigned ByteOffW = $clog2(StrbWidth);

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [IdxW-1:0]      word_idx;
  logic [DataWidth-1:0] rdata_q;

  // word k holds base+k over its own inverse
  for (genvar k = 0; k < RomWords; k++) begin : g_table
    localparam logic [31:0] Hi = RomHiBase + k;
    assign rom_table[k] = {Hi, ~Hi};
  end

  assign word_idx = req_i.addr.flat[ByteOffW +: IdxW];

  // writes never reach the table
  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= rom_table[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/data_sram.sv */
// --------------------------------------------------
// data sram
// word-addressed memory with byte-enable writes
// and a registered read port
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                          clk_i,
  input  soc_pkg::bus_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IdxW     = (RamWords > 1) ? $clog2(RamWords) : 1;
  localparam int unsigned ByteOffW = $clog2(StrbWidth);

  logic [DataWidth-1:0] mem [RamWords];
  logic [IdxW-1:0]      word_idx;
  logic [DataWidth-1:0] rdata_q;

  // word index wraps at the memory depth
  assign word_idx = IdxW'((req_i.addr.flat >> ByteOffW) % RamWords);

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // read data holds until the next read
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/clint_timer.sv */
// --------------------------------------------------
// core-local timer
// mtime counts synchronized rtc edges, mtimecmp
// drives the timer interrupt, msip drives the ipi
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          rtc_i,
  input  soc_pkg::bus_req_t             req_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          hit_o,
  output logic                          timer_irq_o,
  output logic                          ipi_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mtime_q, mtimecmp_q;
  logic                 msip_q;
  logic                 irq_q;
  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 rtc_tick;
  logic                 sel_msip, sel_cmp, sel_time;
  logic                 wr;

  // merge write data into a register under byte enables
  function automatic logic [DataWidth-1:0] merge_be(
    input logic [DataWidth-1:0] old_val,
    input logic [DataWidth-1:0] new_val,
    input logic [StrbWidth-1:0] be
  );
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // rtc synchronizer and edge detect
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_tick = rtc_sync_q[1] & ~rtc_prev_q;

  // offset decode
  assign sel_msip = (req_i.addr.region.offset == MsipOffset);
  assign sel_cmp  = (req_i.addr.region.offset == MtimecmpOffset);
  assign sel_time = (req_i.addr.region.offset == MtimeOffset);
  assign hit_o    = req_i.req & (sel_msip | sel_cmp | sel_time);
  assign wr       = hit_o & req_i.we;

  // --------------------------------------------------
  // registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      // a bus write wins over the tick
      if (wr && sel_time) mtime_q <= merge_be(mtime_q, req_i.wdata, req_i.be);
      else if (rtc_tick) mtime_q <= mtime_q + 1'b1;
      if (wr && sel_cmp) mtimecmp_q <= merge_be(mtimecmp_q, req_i.wdata, req_i.be);
      if (wr && sel_msip && req_i.be[0]) msip_q <= req_i.wdata[0];
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    rdata_o = '0;
    if (sel_msip) rdata_o = {{(DataWidth-1){1'b0}}, msip_q};
    else if (sel_cmp) rdata_o = mtimecmp_q;
    else if (sel_time) rdata_o = mtime_q;
  end

  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

/* source/debug_front.sv */
// --------------------------------------------------
// debug front end
// picks jtag or dmi as debug source, muxes the exit
// code and holds the core debug request off for a
// fixed window after reset
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module debug_front #(
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              jtag_en_i,
  input  soc_pkg::dbg_src_t dbg_jtag_i,
  input  soc_pkg::dbg_src_t dbg_dmi_i,
  output logic [31:0]       exit_o,
  output logic              debug_req_o
);
  import soc_pkg::*;

  localparam int unsigned CntW = (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  dbg_src_t        sel_src;
  logic [CntW-1:0] holdoff_q;
  logic            holdoff_active;

  // source select
  assign sel_src = jtag_en_i ? dbg_jtag_i : dbg_dmi_i;
  assign exit_o  = sel_src.exit_code;

  // --------------------------------------------------
  // hold-off counter
  // --------------------------------------------------
  // gives the core time to run boot code before the
  // first halt request can reach it
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      holdoff_q <= CntW'(DbgDelayCycles);
    end else if (holdoff_active) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  assign holdoff_active = (holdoff_q != '0);
  assign debug_req_o    = holdoff_active ? 1'b0 : sel_src.halt_req;

endmodule

`default_nettype wire

/* source/harness_top.sv */
// --------------------------------------------------
// test harness top
// one request bus fanned out to boot rom, data sram
// and timer, plus the debug front end
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module harness_top #(
  parameter int unsigned RamWords       = 1024,
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  input  soc_pkg::dbg_src_t dbg_jtag_i,
  input  soc_pkg::dbg_src_t dbg_dmi_i,
  input  logic              jtag_en_i,
  output logic [31:0]       exit_o,
  output logic              debug_req_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);
  import soc_pkg::*;

  bus_req_t             rom_req, ram_req, clint_req;
  logic [DataWidth-1:0] rom_rdata, ram_rdata, clint_rdata;
  logic                 clint_hit;

  // --------------------------------------------------
  // bus fabric
  // --------------------------------------------------
  addr_decoder #(
    .RamWords ( RamWords )
  ) addr_decoder_inst (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .bus_req_i     ( bus_req_i   ),
    .bus_rsp_o     ( bus_rsp_o   ),
    .rom_req_o     ( rom_req     ),
    .ram_req_o     ( ram_req     ),
    .clint_req_o   ( clint_req   ),
    .rom_rdata_i   ( rom_rdata   ),
    .ram_rdata_i   ( ram_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .clint_hit_i   ( clint_hit   )
  );

  boot_rom boot_rom_inst (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  data_sram #(
    .RamWords ( RamWords )
  ) data_sram_inst (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .rdata_o ( ram_rdata )
  );

  clint_timer clint_timer_inst (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .hit_o       ( clint_hit   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // --------------------------------------------------
  // debug
  // --------------------------------------------------
  debug_front #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) debug_front_inst (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .jtag_en_i   ( jtag_en_i   ),
    .dbg_jtag_i  ( dbg_jtag_i  ),
    .dbg_dmi_i   ( dbg_dmi_i   ),
    .exit_o      ( exit_o      ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

/* bench/harness_assert.sv */
// --------------------------------------------------
// harness assertions
// response timing, error qualification, reset state
// and the debug hold-off window of the harness top
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module harness_assert #(
  parameter int unsigned HoldCycles = 40
) (
  input logic              clk_i,
  input logic              ndmreset_n,
  input soc_pkg::bus_req_t bus_req_i,
  input soc_pkg::bus_rsp_t bus_rsp_i,
  input logic              debug_req_i,
  input logic              timer_irq_i,
  input logic              ipi_i
);
  int unsigned since_reset_q;
  int          fail_rsp = 0;
  int          fail_idle = 0;
  int          fail_err = 0;
  int          fail_hold = 0;
  int          fail_reset = 0;
  int          fail_cnt;

  // counts cycles after reset release up to the window
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      since_reset_q <= 0;
    end else if (since_reset_q < HoldCycles) begin
      since_reset_q <= since_reset_q + 1;
    end
  end

  always_comb fail_cnt = fail_rsp + fail_idle + fail_err + fail_hold + fail_reset;

  rsp_after_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    bus_req_i.req |=> bus_rsp_i.rvalid)
    else begin
      fail_rsp++;
      $error("rvalid missing one cycle after req");
    end

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !bus_req_i.req |=> !bus_rsp_i.rvalid)
    else begin
      fail_idle++;
      $error("rvalid without a request");
    end

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    bus_rsp_i.err |-> bus_rsp_i.rvalid)
    else begin
      fail_err++;
      $error("err outside a response");
    end

  holdoff_window: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (since_reset_q < HoldCycles) |-> !debug_req_i)
    else begin
      fail_hold++;
      $error("debug request inside hold-off window");
    end

  // first clock edge after reset release
  idle_after_reset: assert property (@(posedge clk_i)
    $rose(ndmreset_n) |->
      (!bus_rsp_i.rvalid && !bus_rsp_i.err && !timer_irq_i && !ipi_i && !debug_req_i))
    else begin
      fail_reset++;
      $error("outputs active right after reset release");
    end

endmodule

bind harness_top harness_assert #(
  .HoldCycles ( DbgDelayCycles )
) harness_assert_inst (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .bus_req_i   ( bus_req_i   ),
  .bus_rsp_i   ( bus_rsp_o   ),
  .debug_req_i ( debug_req_o ),
  .timer_irq_i ( timer_irq_o ),
  .ipi_i       ( ipi_o       )
);

`default_nettype wire

/* bench/harness_tb.sv */
// --------------------------------------------------
// harness testbench
// drives the request bus, rtc tick and debug sources,
// checks responses against shadow models and rules
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module harness_tb;
  import soc_pkg::*;

  localparam int unsigned RamWords = 1024;
  localparam int unsigned DbgDelay = 40;
  localparam logic [31:0] JtagExit = 32'h0000_0A5A;
  localparam logic [31:0] DmiExit  = 32'h0000_0C3C;

  logic        clk_i, ndmreset_n, rtc_i, jtag_en;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  dbg_src_t    dbg_jtag, dbg_dmi;
  logic [31:0] exit_code;
  logic        debug_req, timer_irq, ipi;

  logic [31:0] lfsr_state;
  int          err_cnt, pass_tests, fail_tests;
  int          cyc_q;
  int          ram_idx [16];
  logic [63:0] shadow_mem [int];
  logic [31:0] burst_addr [16];
  logic [63:0] burst_data [16];

  harness_top #(
    .RamWords       ( RamWords ),
    .DbgDelayCycles ( DbgDelay )
  ) harness_top_inst (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .rtc_i       ( rtc_i      ),
    .bus_req_i   ( bus_req    ),
    .bus_rsp_o   ( bus_rsp    ),
    .dbg_jtag_i  ( dbg_jtag   ),
    .dbg_dmi_i   ( dbg_dmi    ),
    .jtag_en_i   ( jtag_en    ),
    .exit_o      ( exit_code  ),
    .debug_req_o ( debug_req  ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        )
  );

  always #5 clk_i = ~clk_i;

  // posedges since reset release
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) cyc_q <= 0;
    else cyc_q <= cyc_q + 1;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [63:0] apply_be(input logic [63:0] old_val,
                                           input logic [63:0] new_val,
                                           input logic [7:0]  be);
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("Error: %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      err_cnt++;
    end
  endtask

  task automatic report_result(input string name, input int start);
    if (err_cnt == start) begin
      pass_tests++;
      $display("[%s] done, no errors", name);
    end else begin
      fail_tests++;
      $display("[%s] done, %0d errors", name, err_cnt - start);
    end
  endtask

  // single request, response sampled on the falling edge after it
  task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [7:0] be,
                          input logic [63:0] wdata, output bus_rsp_t rsp);
    int waited;
    @(negedge clk_i);
    bus_req.req       = 1'b1;
    bus_req.we        = we;
    bus_req.addr.flat = addr;
    bus_req.be        = be;
    bus_req.wdata     = wdata;
    @(negedge clk_i);
    bus_req = '0;
    waited  = 0;
    while (!bus_rsp.rvalid && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    check_cond(bus_rsp.rvalid, "no bus response within 8 cycles");
    rsp = bus_rsp;
  endtask

  // back-to-back reads, one response per cycle in request order
  task automatic burst_read(input int n);
    for (int i = 0; i <= n; i++) begin
      @(negedge clk_i);
      if (i > 0) begin
        check_cond(bus_rsp.rvalid, "burst response missing in its cycle");
        check_val("bus_rsp_o.err", 64'(0), 64'(bus_rsp.err));
        burst_data[i-1] = bus_rsp.rdata;
      end
      bus_req = '0;
      if (i < n) begin
        bus_req.req       = 1'b1;
        bus_req.addr.flat = burst_addr[i];
      end
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic reset_state_check();
    int       start;
    bus_rsp_t rsp;
    start = err_cnt;
    check_val("bus_rsp_o.rvalid", 64'(0), 64'(bus_rsp.rvalid));
    check_val("timer_irq_o", 64'(0), 64'(timer_irq));
    check_val("ipi_o", 64'(0), 64'(ipi));
    check_val("debug_req_o", 64'(0), 64'(debug_req));
    bus_xfer(1'b0, {ClintTag, MtimeOffset}, 8'h00, 64'(0), rsp);
    assert (rsp.rdata < 64'd4) else begin
      $display("Error: mtime expected below %h got %h", 64'd4, rsp.rdata);
      err_cnt++;
    end
    report_result("reset", start);
  endtask

  task automatic debug_holdoff_and_select();
    int start, waited;
    start  = err_cnt;
    waited = 0;
    while (!debug_req && waited < 200) begin
      check_val("debug_req_o", 64'(cyc_q >= int'(DbgDelay)), 64'(debug_req));
      @(negedge clk_i);
      waited++;
    end
    check_cond(debug_req, "debug request never rose after the hold-off window");
    check_cond(cyc_q >= int'(DbgDelay), "debug request rose inside the hold-off window");
    dbg_dmi.halt_req = 1'b0;
    @(negedge clk_i);
    check_val("exit_o", 64'(JtagExit), 64'(exit_code));
    check_val("debug_req_o", 64'(1), 64'(debug_req));
    jtag_en = 1'b0;
    @(negedge clk_i);
    check_val("exit_o", 64'(DmiExit), 64'(exit_code));
    check_val("debug_req_o", 64'(0), 64'(debug_req));
    jtag_en          = 1'b1;
    dbg_dmi.halt_req = 1'b1;
    @(negedge clk_i);
    check_val("exit_o", 64'(JtagExit), 64'(exit_code));
    check_val("debug_req_o", 64'(1), 64'(debug_req));
    report_result("debug", start);
  endtask

  task automatic ram_shadow_compare();
    int          start, idx;
    logic [63:0] v, d;
    bus_rsp_t    rsp;
    start = err_cnt;
    // full-word writes first, so every word read back is defined
    for (int i = 0; i < 16; i++) begin
      draw_bits(10, v);
      idx        = int'(v[9:0]);
      ram_idx[i] = idx;
      draw_bits(64, d);
      bus_xfer(1'b1, {RamTag, 24'(idx * 8)}, 8'hff, d, rsp);
      shadow_mem[idx] = d;
      check_val("bus_rsp_o.err", 64'(0), 64'(rsp.err));
    end
    for (int i = 0; i < 16; i++) begin
      draw_bits(8, v);
      draw_bits(64, d);
      idx = ram_idx[i];
      bus_xfer(1'b1, {RamTag, 24'(idx * 8)}, v[7:0], d, rsp);
      shadow_mem[idx] = apply_be(shadow_mem[idx], d, v[7:0]);
    end
    for (int i = 0; i < 16; i++) burst_addr[i] = {RamTag, 24'(ram_idx[i] * 8)};
    burst_read(16);
    for (int i = 0; i < 16; i++) begin
      check_val("bus_rsp_o.rdata", shadow_mem[ram_idx[i]], burst_data[i]);
    end
    report_result("ram", start);
  endtask

  task automatic rom_content_check();
    int          start, k;
    logic [63:0] v;
    logic [31:0] hi;
    bus_rsp_t    rsp;
    start = err_cnt;
    for (int i = 0; i < 8; i++) begin
      draw_bits(9, v);
      k  = int'(v[8:0]);
      hi = RomHiBase + 32'(k);
      if (i >= 5) begin
        draw_bits(64, v);
        bus_xfer(1'b1, {RomTag, 24'(k * 8)}, 8'hff, v, rsp);
        check_val("bus_rsp_o.err", 64'(0), 64'(rsp.err));
        check_val("bus_rsp_o.rdata", 64'(0), rsp.rdata);
      end
      bus_xfer(1'b0, {RomTag, 24'(k * 8)}, 8'h00, 64'(0), rsp);
      check_val("bus_rsp_o.err", 64'(0), 64'(rsp.err));
      check_val("bus_rsp_o.rdata", {hi, ~hi}, rsp.rdata);
    end
    report_result("rom", start);
  endtask

  task automatic unmapped_errors();
    int          start, idx;
    logic [63:0] v, d;
    logic [7:0]  tag;
    bus_rsp_t    rsp;
    start = err_cnt;
    for (int i = 0; i < 6; i++) begin
      draw_bits(8, v);
      tag = v[7:0];
      if (tag == RomTag || tag == ClintTag || tag == RamTag) tag = tag ^ 8'h40;
      draw_bits(24, v);
      draw_bits(64, d);
      bus_xfer(d[0], {tag, v[23:0]}, 8'hff, d, rsp);
      check_val("bus_rsp_o.err", 64'(1), 64'(rsp.err));
      check_val("bus_rsp_o.rdata", 64'(0), rsp.rdata);
    end
    // past the rom limit and a hole in the timer region
    draw_bits(12, v);
    bus_xfer(1'b0, {RomTag, 24'h00_1000 | 24'(v[11:0])}, 8'h00, 64'(0), rsp);
    check_val("bus_rsp_o.err", 64'(1), 64'(rsp.err));
    bus_xfer(1'b0, {ClintTag, 24'h00_0008}, 8'h00, 64'(0), rsp);
    check_val("bus_rsp_o.err", 64'(1), 64'(rsp.err));
    // offset past the ram limit that aliases a written word
    idx = ram_idx[0];
    draw_bits(64, d);
    bus_xfer(1'b1, {RamTag, 24'h00_2000 + 24'(idx * 8)}, 8'hff, d, rsp);
    check_val("bus_rsp_o.err", 64'(1), 64'(rsp.err));
    check_val("bus_rsp_o.rdata", 64'(0), rsp.rdata);
    bus_xfer(1'b0, {RamTag, 24'(idx * 8)}, 8'h00, 64'(0), rsp);
    check_val("bus_rsp_o.rdata", shadow_mem[idx], rsp.rdata);
    report_result("unmapped", start);
  endtask

  task automatic timer_and_ipi();
    int          start, waited;
    logic [63:0] now;
    bus_rsp_t    rsp;
    start = err_cnt;
    bus_xfer(1'b0, {ClintTag, MtimeOffset}, 8'h00, 64'(0), rsp);
    now = rsp.rdata;
    bus_xfer(1'b1, {ClintTag, MtimecmpOffset}, 8'hff, now + 64'd3, rsp);
    check_val("bus_rsp_o.err", 64'(0), 64'(rsp.err));
    bus_xfer(1'b0, {ClintTag, MtimecmpOffset}, 8'h00, 64'(0), rsp);
    check_val("bus_rsp_o.rdata", now + 64'd3, rsp.rdata);
    check_val("timer_irq_o", 64'(0), 64'(timer_irq));
    // rtc toggles every 4 cycles
    waited = 0;
    while (!timer_irq && waited < 200) begin
      @(negedge clk_i);
      waited++;
      rtc_i = waited[2];
    end
    rtc_i = 1'b0;
    check_cond(timer_irq, "timer interrupt did not rise within 200 cycles");
    bus_xfer(1'b0, {ClintTag, MtimeOffset}, 8'h00, 64'(0), rsp);
    assert (rsp.rdata >= now + 64'd3) else begin
      $display("Error: mtime expected at least %h got %h", now + 64'd3, rsp.rdata);
      err_cnt++;
    end
    bus_xfer(1'b1, {ClintTag, MtimecmpOffset}, 8'hff, '1, rsp);
    waited = 0;
    while (timer_irq && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    check_cond(!timer_irq, "timer interrupt did not clear after mtimecmp rewrite");
    bus_xfer(1'b1, {ClintTag, MsipOffset}, 8'h01, 64'(1), rsp);
    waited = 0;
    while (!ipi && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    check_cond(ipi, "ipi did not rise after msip write");
    bus_xfer(1'b1, {ClintTag, MsipOffset}, 8'h01, 64'(0), rsp);
    waited = 0;
    while (ipi && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    check_cond(!ipi, "ipi did not clear after msip write");
    report_result("timer", start);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    clk_i      = 1'b0;
    ndmreset_n = 1'b0;
    rtc_i      = 1'b0;
    jtag_en    = 1'b1;
    bus_req    = '0;
    dbg_jtag.halt_req  = 1'b1;
    dbg_jtag.exit_code = JtagExit;
    dbg_dmi.halt_req   = 1'b1;
    dbg_dmi.exit_code  = DmiExit;
    lfsr_state = 32'h8759622f;
    err_cnt    = 0;
    pass_tests = 0;
    fail_tests = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    ndmreset_n = 1'b1;
    reset_state_check();
    debug_holdoff_and_select();
    ram_shadow_compare();
    rom_content_check();
    unmapped_errors();
    timer_and_ipi();
    $display("tests passed: %0d failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && harness_top_inst.harness_assert_inst.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // overall limit on the run
  initial begin
    #1_000_000;
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
source/soc_pkg.sv
source/addr_decoder.sv
source/boot_rom.sv
source/data_sram.sv
source/clint_timer.sv
source/debug_front.sv
source/harness_top.sv
bench/harness_assert.sv
bench/harness_tb.sv

/* Makefile */
TOP := harness_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
